/* filelist.f */
+incdir+include
rtl/pipe_pkg.sv
rtl/dff_lrc.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/id_ex.sv
rtl/ex_stage.sv
rtl/pipe_ctrl.sv
rtl/core_slice_top.sv
test/core_slice_props.sv
test/core_slice_checker.sv
test/core_slice_tb.sv

/* include/pipe_consts.svh */
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Data path and register file sizes
`define XLEN            32
`define REG_NUM         32

// Major opcodes handled by the slice
`define OPC_OP          7'b0110011
`define OPC_OP_IMM      7'b0010011
`define OPC_LUI         7'b0110111

`define F3_ADD          3'b000
`define F3_SLT          3'b010
`define F3_XOR          3'b100
`define F3_OR           3'b110
`define F3_AND          3'b111

// Bit of funct7 that turns ADD into SUB
`define F7_SUB_BIT      5

// Stall vector bit positions
`define STALL_ID        2
`define STALL_EX        3

`endif

/* rtl/core_slice_top.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module core_slice_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  pipe_pkg::word_t     inst_i,
    input  pipe_pkg::word_t     pc_i,
    input  logic                stall_id_req_i,
    input  logic                stall_ex_req_i,
    output logic                id_stall_o,
    output logic                wb_we_o,
    output pipe_pkg::reg_addr_t wb_addr_o,
    output pipe_pkg::word_t     wb_data_o
);

    pipe_pkg::stall_t    stall;

    pipe_pkg::reg_addr_t rs1_addr;
    pipe_pkg::reg_addr_t rs2_addr;
    pipe_pkg::word_t     rs1_data;
    pipe_pkg::word_t     rs2_data;

    pipe_pkg::word_t     id_pc;
    pipe_pkg::word_t     id_op1_data;
    pipe_pkg::word_t     id_op2_data;
    pipe_pkg::word_t     id_imm_data;
    pipe_pkg::reg_addr_t id_rd_addr;
    logic                id_rd_we;
    pipe_pkg::dec_info_t id_dec_info;

    pipe_pkg::word_t     ex_pc;
    pipe_pkg::word_t     ex_op1_data;
    pipe_pkg::word_t     ex_op2_data;
    pipe_pkg::word_t     ex_imm_data;
    pipe_pkg::reg_addr_t ex_rd_addr;
    logic                ex_rd_we;
    pipe_pkg::dec_info_t ex_dec_info;

    assign id_stall_o = stall[`STALL_ID];

    pipe_ctrl pipe_ctrl_inst (
        .stall_id_req_i, .stall_ex_req_i, .stall_o(stall)
    );

    regfile regfile_inst (
        .clk_i, .rst_n_i,
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(wb_we_o), .waddr_i(wb_addr_o), .wdata_i(wb_data_o)
    );

    id_stage id_stage_inst (
        .inst_valid_i, .inst_i, .pc_i, .stall_id_i(stall[`STALL_ID]),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .pc_o(id_pc), .op1_data_o(id_op1_data), .op2_data_o(id_op2_data),
        .imm_data_o(id_imm_data), .rd_addr_o(id_rd_addr), .rd_we_o(id_rd_we),
        .dec_info_o(id_dec_info)
    );

    id_ex id_ex_inst (
        .clk_i, .rst_n_i, .stall_i(stall),
        .pc_i(id_pc), .op1_data_i(id_op1_data), .op2_data_i(id_op2_data),
        .imm_data_i(id_imm_data), .rd_addr_i(id_rd_addr), .rd_we_i(id_rd_we),
        .dec_info_bus_i(id_dec_info),
        .pc_o(ex_pc), .op1_data_o(ex_op1_data), .op2_data_o(ex_op2_data),
        .imm_data_o(ex_imm_data), .rd_addr_o(ex_rd_addr), .rd_we_o(ex_rd_we),
        .dec_info_bus_o(ex_dec_info)
    );

    ex_stage ex_stage_inst (
        .pc_i(ex_pc), .op1_data_i(ex_op1_data), .op2_data_i(ex_op2_data),
        .imm_data_i(ex_imm_data), .rd_addr_i(ex_rd_addr), .rd_we_i(ex_rd_we),
        .dec_info_bus_i(ex_dec_info),
        .wb_we_o, .wb_addr_o, .wb_data_o
    );

endmodule

/* rtl/dff_lrc.sv */
`timescale 1ns/1ps

module dff_lrc #(
    parameter type T       = pipe_pkg::word_t,
    parameter T    RST_VAL = T'('0)
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic clr_i,
    input  logic load_i,
    input  T     d_i,
    output T     q_o
);

    T q_r;

    // Clear wins over load, otherwise the value is held
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_r <= RST_VAL;
        end else if (clr_i) begin
            q_r <= RST_VAL;
        end else if (load_i) begin
            q_r <= d_i;
        end
    end

    assign q_o = q_r;

endmodule

/* rtl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  pipe_pkg::word_t     pc_i,
    input  pipe_pkg::word_t     op1_data_i,
    input  pipe_pkg::word_t     op2_data_i,
    input  pipe_pkg::word_t     imm_data_i,
    input  pipe_pkg::reg_addr_t rd_addr_i,
    input  logic                rd_we_i,
    input  pipe_pkg::dec_info_t dec_info_bus_i,
    output logic                wb_we_o,
    output pipe_pkg::reg_addr_t wb_addr_o,
    output pipe_pkg::word_t     wb_data_o
);

    pipe_pkg::word_t op_b;

    // pc_i is reserved for branch target computation
    assign op_b = dec_info_bus_i.use_imm ? imm_data_i : op2_data_i;

    always_comb begin
        case (dec_info_bus_i.alu_op)
            pipe_pkg::ADD:    wb_data_o = op1_data_i + op_b;
            pipe_pkg::SUB:    wb_data_o = op1_data_i - op_b;
            pipe_pkg::AND:    wb_data_o = op1_data_i & op_b;
            pipe_pkg::OR:     wb_data_o = op1_data_i | op_b;
            pipe_pkg::XOR:    wb_data_o = op1_data_i ^ op_b;
            pipe_pkg::SLT: begin
                wb_data_o = '0;
                wb_data_o[0] = $signed(op1_data_i) < $signed(op_b);
            end
            pipe_pkg::PASS_B: wb_data_o = op_b;
            default:          wb_data_o = '0;
        endcase
    end

    assign wb_we_o   = rd_we_i;
    assign wb_addr_o = rd_addr_i;

endmodule

/* rtl/id_ex.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module id_ex (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::stall_t    stall_i,

    input  pipe_pkg::word_t     pc_i,
    input  pipe_pkg::word_t     op1_data_i,
    input  pipe_pkg::word_t     op2_data_i,
    input  pipe_pkg::word_t     imm_data_i,
    input  pipe_pkg::reg_addr_t rd_addr_i,
    input  logic                rd_we_i,
    input  pipe_pkg::dec_info_t dec_info_bus_i,

    output pipe_pkg::word_t     pc_o,
    output pipe_pkg::word_t     op1_data_o,
    output pipe_pkg::word_t     op2_data_o,
    output pipe_pkg::word_t     imm_data_o,
    output pipe_pkg::reg_addr_t rd_addr_o,
    output logic                rd_we_o,
    output pipe_pkg::dec_info_t dec_info_bus_o
);

    logic clr;
    logic load;

    // Decode stalled while execute runs on, so a bubble goes down the pipe
    assign clr  = stall_i[`STALL_ID] & ~stall_i[`STALL_EX];
    assign load = ~stall_i[`STALL_ID];

    dff_lrc #(.T(pipe_pkg::word_t)) dff_pc (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(pc_i), .q_o(pc_o)
    );

    dff_lrc #(.T(pipe_pkg::word_t)) dff_op1_data (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(op1_data_i), .q_o(op1_data_o)
    );

    dff_lrc #(.T(pipe_pkg::word_t)) dff_op2_data (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(op2_data_i), .q_o(op2_data_o)
    );

    dff_lrc #(.T(pipe_pkg::word_t)) dff_imm_data (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(imm_data_i), .q_o(imm_data_o)
    );

    dff_lrc #(.T(pipe_pkg::reg_addr_t)) dff_rd_addr (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(rd_addr_i), .q_o(rd_addr_o)
    );

    dff_lrc #(.T(logic)) dff_rd_we (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(rd_we_i), .q_o(rd_we_o)
    );

    dff_lrc #(.T(pipe_pkg::dec_info_t)) dff_dec_info_bus (
        .clk_i, .rst_n_i, .clr_i(clr), .load_i(load), .d_i(dec_info_bus_i),
        .q_o(dec_info_bus_o)
    );

endmodule

/* rtl/id_stage.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module id_stage (
    input  logic                inst_valid_i,
    input  pipe_pkg::word_t     inst_i,
    input  pipe_pkg::word_t     pc_i,
    input  logic                stall_id_i,
    output pipe_pkg::reg_addr_t rs1_addr_o,
    output pipe_pkg::reg_addr_t rs2_addr_o,
    input  pipe_pkg::word_t     rs1_data_i,
    input  pipe_pkg::word_t     rs2_data_i,
    output pipe_pkg::word_t     pc_o,
    output pipe_pkg::word_t     op1_data_o,
    output pipe_pkg::word_t     op2_data_o,
    output pipe_pkg::word_t     imm_data_o,
    output pipe_pkg::reg_addr_t rd_addr_o,
    output logic                rd_we_o,
    output pipe_pkg::dec_info_t dec_info_o
);

    logic [6:0]          opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    pipe_pkg::reg_addr_t rd;
    logic                supported;

    assign opcode = inst_i[6:0];
    assign rd     = inst_i[11:7];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    always_comb begin
        supported          = 1'b1;
        dec_info_o.alu_op  = pipe_pkg::ADD;
        dec_info_o.use_imm = 1'b0;
        imm_data_o         = {{20{inst_i[31]}}, inst_i[31:20]};
        case (opcode)
            `OPC_OP: begin
                case (funct3)
                    `F3_ADD: dec_info_o.alu_op = funct7[`F7_SUB_BIT] ? pipe_pkg::SUB
                                                                      : pipe_pkg::ADD;
                    `F3_SLT: dec_info_o.alu_op = pipe_pkg::SLT;
                    `F3_XOR: dec_info_o.alu_op = pipe_pkg::XOR;
                    `F3_OR:  dec_info_o.alu_op = pipe_pkg::OR;
                    `F3_AND: dec_info_o.alu_op = pipe_pkg::AND;
                    default: supported = 1'b0;
                endcase
                // Only SUB may set a funct7 bit
                if ((funct7 & ~(7'd1 << `F7_SUB_BIT)) != 7'd0) begin
                    supported = 1'b0;
                end
                if (funct7[`F7_SUB_BIT] && (funct3 != `F3_ADD)) begin
                    supported = 1'b0;
                end
            end
            `OPC_OP_IMM: begin
                dec_info_o.use_imm = 1'b1;
                case (funct3)
                    `F3_ADD: dec_info_o.alu_op = pipe_pkg::ADD;
                    `F3_XOR: dec_info_o.alu_op = pipe_pkg::XOR;
                    `F3_OR:  dec_info_o.alu_op = pipe_pkg::OR;
                    `F3_AND: dec_info_o.alu_op = pipe_pkg::AND;
                    default: supported = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                dec_info_o.alu_op  = pipe_pkg::PASS_B;
                dec_info_o.use_imm = 1'b1;
                imm_data_o         = {inst_i[31:12], 12'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    assign pc_o       = pc_i;
    assign op1_data_o = rs1_data_i;
    assign op2_data_o = rs2_data_i;
    assign rd_addr_o  = rd;

    // Nothing is written back for bubbles, x0 targets or unknown opcodes
    assign rd_we_o = inst_valid_i && !stall_id_i && supported && (rd != '0);

endmodule

/* rtl/pipe_ctrl.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module pipe_ctrl (
    input  logic             stall_id_req_i,
    input  logic             stall_ex_req_i,
    output pipe_pkg::stall_t stall_o
);

    // A busy execute unit freezes everything up to and including itself
    always_comb begin
        stall_o = '0;
        if (stall_ex_req_i) begin
            stall_o[`STALL_EX:0] = '1;
        end else if (stall_id_req_i) begin
            stall_o[`STALL_ID:0] = '1;
        end
    end

endmodule

/* rtl/pipe_pkg.sv */
`include "pipe_consts.svh"

package pipe_pkg;

    typedef logic [`XLEN-1:0] word_t;

    typedef logic [$clog2(`REG_NUM)-1:0] reg_addr_t;

    // ALU operations
    // PASS_B forwards the second operand for LUI
    typedef enum logic [2:0] {
        ADD    = 3'd0,
        SUB    = 3'd1,
        AND    = 3'd2,
        OR     = 3'd3,
        XOR    = 3'd4,
        SLT    = 3'd5,
        PASS_B = 3'd6
    } alu_op_t;

    // Decode info carried from decode to execute
    typedef struct packed {
        alu_op_t alu_op;
        logic    use_imm;
    } dec_info_t;

    // Bit 0 pc, 1 fetch, 2 decode, 3 execute, 4 and 5 reserved
    typedef logic [5:0] stall_t;

endpackage

/* rtl/regfile.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::reg_addr_t rs1_addr_i,
    input  pipe_pkg::reg_addr_t rs2_addr_i,
    output pipe_pkg::word_t     rs1_data_o,
    output pipe_pkg::word_t     rs2_data_o,
    input  logic                we_i,
    input  pipe_pkg::reg_addr_t waddr_i,
    input  pipe_pkg::word_t     wdata_i
);

    // x0 has no storage
    pipe_pkg::word_t regs [1:`REG_NUM-1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // A read of the register being written returns the new value
    assign rs1_data_o = (rs1_addr_i == '0)                   ? '0      :
                        (we_i && (waddr_i == rs1_addr_i))    ? wdata_i :
                                                               regs[rs1_addr_i];

    assign rs2_data_o = (rs2_addr_i == '0)                   ? '0      :
                        (we_i && (waddr_i == rs2_addr_i))    ? wdata_i :
                                                               regs[rs2_addr_i];

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the core slice testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module core_slice_tb \
    -f filelist.f -o core_slice_sim || exit 1
sim_out=$(./obj_dir/core_slice_sim +verilator+error+limit+1000)
echo "$sim_out"
echo "$sim_out" | grep -qx "=== PASS ===" && echo "Simulation passed" || {
    echo "Simulation failed"
    exit 1
}

/* test/core_slice_checker.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module core_slice_checker (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  pipe_pkg::word_t     inst_i,
    input  logic                stall_id_req_i,
    input  logic                stall_ex_req_i,
    input  logic                exp_chk_i,
    input  pipe_pkg::word_t     exp_data_i,
    input  logic                id_stall_i,
    input  logic                wb_we_i,
    input  pipe_pkg::reg_addr_t wb_addr_i,
    input  pipe_pkg::word_t     wb_data_i,
    output int                  error_count_o
);

    pipe_pkg::word_t     model_regs [`REG_NUM];
    logic                pend_we;
    pipe_pkg::reg_addr_t pend_addr;
    pipe_pkg::word_t     pend_data;
    logic                pend_chk;
    pipe_pkg::word_t     pend_exp;
    logic                seen_valid;
    logic                checking   = 1'b0;
    logic                stall_seen;
    logic                stall_want;
    int                  errors     = 0;

    assign error_count_o = errors;

    // RV32I semantics of the supported subset, read from the model registers
    task automatic take(input pipe_pkg::word_t inst);
        pipe_pkg::word_t a;
        pipe_pkg::word_t b;
        pipe_pkg::word_t imm;
        logic            ok;
        a         = model_regs[inst[19:15]];
        b         = model_regs[inst[24:20]];
        imm       = {{20{inst[31]}}, inst[31:20]};
        ok        = 1'b1;
        pend_data = '0;
        case (inst[6:0])
            `OPC_LUI: pend_data = {inst[31:12], 12'h000};
            `OPC_OP_IMM: begin
                case (inst[14:12])
                    `F3_ADD: pend_data = a + imm;
                    `F3_XOR: pend_data = a ^ imm;
                    `F3_OR:  pend_data = a | imm;
                    `F3_AND: pend_data = a & imm;
                    default: ok = 1'b0;
                endcase
            end
            `OPC_OP: begin
                case ({inst[31:25], inst[14:12]})
                    {7'h00, `F3_ADD}: pend_data = a + b;
                    {7'h20, `F3_ADD}: pend_data = a - b;
                    {7'h00, `F3_SLT}: pend_data = {31'd0, $signed(a) < $signed(b)};
                    {7'h00, `F3_XOR}: pend_data = a ^ b;
                    {7'h00, `F3_OR}:  pend_data = a | b;
                    {7'h00, `F3_AND}: pend_data = a & b;
                    default:          ok = 1'b0;
                endcase
            end
            default: ok = 1'b0;
        endcase
        pend_we   = ok && (inst[11:7] != 5'd0);
        pend_addr = inst[11:7];
    endtask

    task automatic report(input string name, input pipe_pkg::word_t exp,
                          input pipe_pkg::word_t act);
        errors++;
        $display("FAILED time %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
    endtask

    // Inputs are stable at the rising edge, so the model steps here
    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `REG_NUM; i++) begin
                model_regs[i] = '0;
            end
            pend_we    = 1'b0;
            pend_addr  = '0;
            pend_data  = '0;
            pend_chk   = 1'b0;
            pend_exp   = '0;
            seen_valid = 1'b0;
            checking   = 1'b0;
        end else begin
            stall_seen = id_stall_i;
            stall_want = stall_id_req_i || stall_ex_req_i;
            checking   = 1'b1;
            if (pend_we) begin
                model_regs[pend_addr] = pend_data;
            end
            if (!stall_ex_req_i) begin
                if (stall_id_req_i || !inst_valid_i) begin
                    pend_we  = 1'b0;
                    pend_chk = 1'b0;
                end else begin
                    take(inst_i);
                    pend_chk   = exp_chk_i;
                    pend_exp   = exp_data_i;
                    seen_valid = 1'b1;
                end
            end
        end
    end

    always @(negedge clk_i) begin
        if (checking) begin
            if (stall_seen !== stall_want) begin
                report("id_stall_o", 32'(stall_want), 32'(stall_seen));
            end
            if (wb_we_i !== pend_we) begin
                report("wb_we_o", 32'(pend_we), 32'(wb_we_i));
            end
            // Before the first instruction the port must read zero
            if (pend_we || !seen_valid) begin
                if (wb_addr_i !== pend_addr) begin
                    report("wb_addr_o", 32'(pend_addr), 32'(wb_addr_i));
                end
                if (wb_data_i !== pend_data) begin
                    report("wb_data_o", pend_data, wb_data_i);
                end
            end
            if (pend_chk && (wb_data_i !== pend_exp)) begin
                report("wb_data_o readback", pend_exp, wb_data_i);
            end
        end
    end

endmodule

/* test/core_slice_props.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module core_slice_props (
    input logic                clk_i,
    input logic                rst_n_i,
    input pipe_pkg::stall_t    stall_i,
    input pipe_pkg::word_t     pc_o,
    input pipe_pkg::word_t     op1_data_o,
    input pipe_pkg::word_t     op2_data_o,
    input pipe_pkg::word_t     imm_data_o,
    input pipe_pkg::reg_addr_t rd_addr_o,
    input logic                rd_we_o,
    input pipe_pkg::dec_info_t dec_info_bus_o
);

    logic bubble;
    logic frozen;
    int   clr_fails  = 0;
    int   hold_fails = 0;
    int   rst_fails  = 0;
    int   fail_count;

    assign bubble     = stall_i[`STALL_ID] && !stall_i[`STALL_EX];
    assign frozen     = stall_i[`STALL_ID] && stall_i[`STALL_EX];
    assign fail_count = clr_fails + hold_fails + rst_fails;

    bubble_clears_we: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        bubble |=> !rd_we_o)
        else begin
            $error("id_ex kept rd_we_o high after a bubble");
            clr_fails++;
        end

    // Execute busy freezes every field of the register
    frozen_is_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        frozen |=> $stable({pc_o, op1_data_o, op2_data_o, imm_data_o, rd_addr_o, rd_we_o,
                            dec_info_bus_o}))
        else begin
            $error("id_ex outputs changed while decode and execute were both stalled");
            hold_fails++;
        end

    reset_clears_we: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !rd_we_o)
        else begin
            $error("id_ex rd_we_o not low after reset");
            rst_fails++;
        end

endmodule

/* test/core_slice_tb.sv */
`timescale 1ns/1ps
`include "pipe_consts.svh"

module core_slice_tb;

    localparam int RST_CYCLES = 8;
    // More than three times the table length plus reset
    localparam int MAX_CYCLES = 200;

    logic                clk;
    logic                rst_n;
    logic                inst_valid;
    pipe_pkg::word_t     inst;
    pipe_pkg::word_t     pc;
    logic                stall_id_req;
    logic                stall_ex_req;
    logic                exp_chk;
    pipe_pkg::word_t     exp_data;
    logic                id_stall;
    logic                wb_we;
    pipe_pkg::reg_addr_t wb_addr;
    pipe_pkg::word_t     wb_data;
    int                  check_errors;
    int                  cycles;

    pipe_pkg::word_t tab_inst  [$];
    logic            tab_valid [$];
    logic            tab_sid   [$];
    logic            tab_sex   [$];
    logic            tab_chk   [$];
    pipe_pkg::word_t tab_exp   [$];
    pipe_pkg::word_t exp_reg   [`REG_NUM];

    core_slice_top core_slice_top_inst (
        .clk_i(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(pc),
        .stall_id_req_i(stall_id_req), .stall_ex_req_i(stall_ex_req), .id_stall_o(id_stall),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    core_slice_checker core_slice_checker_inst (
        .clk_i(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid), .inst_i(inst),
        .stall_id_req_i(stall_id_req), .stall_ex_req_i(stall_ex_req), .exp_chk_i(exp_chk),
        .exp_data_i(exp_data), .id_stall_i(id_stall), .wb_we_i(wb_we), .wb_addr_i(wb_addr),
        .wb_data_i(wb_data), .error_count_o(check_errors)
    );

    bind id_ex core_slice_props core_slice_props_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_i(stall_i), .pc_o(pc_o),
        .op1_data_o(op1_data_o), .op2_data_o(op2_data_o), .imm_data_o(imm_data_o),
        .rd_addr_o(rd_addr_o), .rd_we_o(rd_we_o), .dec_info_bus_o(dec_info_bus_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic pipe_pkg::word_t imm_inst(input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, `OPC_OP_IMM};
    endfunction

    function automatic pipe_pkg::word_t reg_inst(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [4:0] rd, input logic [4:0] rs1,
                                                 input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic pipe_pkg::word_t sign_extend(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    task automatic add_row(input pipe_pkg::word_t i, input logic v, input logic sid,
                           input logic sex, input logic chk, input pipe_pkg::word_t e);
        tab_inst.push_back(i);
        tab_valid.push_back(v);
        tab_sid.push_back(sid);
        tab_sex.push_back(sex);
        tab_chk.push_back(chk);
        tab_exp.push_back(e);
    endtask

    task automatic build_table();
        logic [11:0] imm;
        logic [19:0] upper;
        for (int r = 0; r < `REG_NUM; r++) begin
            exp_reg[r] = '0;
        end
        add_row('0, 0, 0, 0, 0, '0);
        add_row('0, 0, 0, 0, 0, '0);
        for (int r = 1; r <= 4; r++) begin
            imm = 12'($urandom);
            add_row(imm_inst(`F3_ADD, 5'(r), 5'd0, imm), 1, 0, 0, 0, '0);
            exp_reg[r] = sign_extend(imm);
        end
        imm = 12'($urandom);
        add_row(imm_inst(`F3_AND, 5, 1, imm), 1, 0, 0, 0, '0);
        exp_reg[5] = exp_reg[1] & sign_extend(imm);
        imm = 12'($urandom);
        add_row(imm_inst(`F3_OR, 6, 2, imm), 1, 0, 0, 0, '0);
        exp_reg[6] = exp_reg[2] | sign_extend(imm);
        imm = 12'($urandom);
        add_row(imm_inst(`F3_XOR, 7, 3, imm), 1, 0, 0, 0, '0);
        exp_reg[7] = exp_reg[3] ^ sign_extend(imm);
        upper = 20'($urandom);
        add_row({upper, 5'd8, `OPC_LUI}, 1, 0, 0, 0, '0);
        exp_reg[8] = {upper, 12'h000};
        add_row(imm_inst(`F3_ADD, 0, 1, 12'h005), 1, 0, 0, 0, '0);
        // Most of these read the result of the row before it
        add_row(reg_inst(7'h00, `F3_ADD, 9, 1, 2), 1, 0, 0, 0, '0);
        exp_reg[9] = exp_reg[1] + exp_reg[2];
        add_row(reg_inst(7'h20, `F3_ADD, 10, 9, 3), 1, 0, 0, 0, '0);
        exp_reg[10] = exp_reg[9] - exp_reg[3];
        add_row(reg_inst(7'h00, `F3_AND, 11, 10, 4), 1, 0, 0, 0, '0);
        exp_reg[11] = exp_reg[10] & exp_reg[4];
        add_row(reg_inst(7'h00, `F3_OR, 12, 11, 5), 1, 0, 0, 0, '0);
        exp_reg[12] = exp_reg[11] | exp_reg[5];
        add_row(reg_inst(7'h00, `F3_XOR, 13, 12, 6), 1, 0, 0, 0, '0);
        exp_reg[13] = exp_reg[12] ^ exp_reg[6];
        add_row(reg_inst(7'h00, `F3_SLT, 14, 13, 7), 1, 0, 0, 0, '0);
        exp_reg[14] = {31'd0, $signed(exp_reg[13]) < $signed(exp_reg[7])};
        add_row(reg_inst(7'h00, `F3_SLT, 15, 7, 13), 1, 0, 0, 0, '0);
        exp_reg[15] = {31'd0, $signed(exp_reg[7]) < $signed(exp_reg[13])};
        for (int k = 0; k < 4; k++) begin
            add_row(imm_inst(`F3_ADD, 16, 9, 12'd100), 1, (k < 3), 0, 0, '0);
        end
        exp_reg[16] = exp_reg[9] + 32'd100;
        add_row(imm_inst(`F3_ADD, 17, 16, 12'hff9), 1, 0, 0, 0, '0);
        exp_reg[17] = exp_reg[16] - 32'd7;
        for (int k = 0; k < 4; k++) begin
            add_row(reg_inst(7'h00, `F3_XOR, 18, 17, 1), 1, 0, (k < 3), 0, '0);
        end
        exp_reg[18] = exp_reg[17] ^ exp_reg[1];
        // None of these may write a register
        add_row(imm_inst(`F3_ADD, 1, 0, 12'h7ff), 0, 0, 0, 0, '0);
        add_row({12'h004, 5'd1, 3'b010, 5'd2, 7'b0000011}, 1, 0, 0, 0, '0);
        add_row(reg_inst(7'h00, 3'b001, 3, 1, 2), 1, 0, 0, 0, '0);
        add_row(imm_inst(3'b010, 4, 1, 12'h001), 1, 0, 0, 0, '0);
        add_row(reg_inst(7'h20, `F3_XOR, 5, 1, 2), 1, 0, 0, 0, '0);
        for (int r = 1; r <= 18; r++) begin
            add_row(imm_inst(`F3_ADD, 5'(r), 5'(r), 12'h000), 1, 0, 0, 1, exp_reg[r]);
        end
        add_row('0, 0, 0, 0, 0, '0);
        add_row('0, 0, 0, 0, 0, '0);
    endtask

    initial begin
        void'($urandom(2750));
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        stall_id_req = 1'b0;
        stall_ex_req = 1'b0;
        exp_chk      = 1'b0;
        exp_data     = '0;
        rst_n        = 1'b0;
        build_table();
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < tab_inst.size(); i++) begin
            inst_valid   = tab_valid[i];
            inst         = tab_inst[i];
            pc           = 32'h0000_1000 + 32'(i * 4);
            stall_id_req = tab_sid[i];
            stall_ex_req = tab_sex[i];
            exp_chk      = tab_chk[i];
            exp_data     = tab_exp[i];
            @(negedge clk);
        end
        @(posedge clk);
        $display("Run complete: %0d checker errors, %0d assertion failures", check_errors,
                 core_slice_top_inst.id_ex_inst.core_slice_props_inst.fail_count);
        if ((check_errors == 0) &&
            (core_slice_top_inst.id_ex_inst.core_slice_props_inst.fail_count == 0)) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: stimulus table still running after %0d cycles", MAX_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
